//--- all.f
r10k_pkg.sv
fetch.sv
inst_buffer.sv
decoder.sv
free_list.sv
rob.sv
dispatch.sv
cpu.sv
tb_cpu.sv

//--- Makefile
# Verilator build and run of the rename core testbench

VERILATOR  ?= verilator
TOP        ?= tb_cpu
DUT_TOP    ?= cpu
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "No result in $(LOG)"; exit 1)
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) \
		r10k_pkg.sv fetch.sv inst_buffer.sv decoder.sv free_list.sv rob.sv dispatch.sv cpu.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_cpu.sv
// Random run of NUM_TESTS instructions; imem stops answering after that, so fetch ends parked in REQ
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int NUM_TESTS  = 200;                     // Instructions fetched and committed
    localparam int WORST_LAT  = 64;                      // Generous cycles per instruction
    localparam int TIMEOUT_NS = NUM_TESTS * WORST_LAT * 8 * 4;

    logic                    clock;
    logic                    rst_n;
    logic                    imem_ack;
    logic [31:0]             imem_data;
    r10k_pkg::complete_pkt_t complete_in;
    logic                    imem_req;
    r10k_pkg::addr_t         imem_addr;
    r10k_pkg::dispatch_pkt_t dispatch_out;
    r10k_pkg::commit_pkt_t   commit_out;

    integer seed = 32'h110cad49;
    int     cycle = 0;
    int     delay_cnt = 0;                               // Cycles left before the next ack
    int     disp_cnt = 0;
    int     commit_cnt = 0;
    int     err_dispatch = 0;
    int     err_commit = 0;
    int     err_ctrl = 0;
    int     err_other = 0;
    logic   stall_seen = 1'b0;                           // ROB filled at least once

    // Model state
    logic [31:0]             words [$];                  // Fetched words indexed by PC/4
    r10k_pkg::phys_reg_t     model_map [r10k_pkg::ARCH_REGS];
    r10k_pkg::phys_reg_t     model_fl [$];
    r10k_pkg::commit_pkt_t   exp_commits [$];
    r10k_pkg::rob_idx_t      pend_idx [$];               // Dispatched and not yet completed

    cpu i_dut (
        .clock(clock), .rst_n(rst_n),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack), .imem_data(imem_data),
        .dispatch_out(dispatch_out), .complete_in(complete_in), .commit_out(commit_out)
    );

    always #4 clock = ~clock;                            // 8 ns period

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_dispatch(string name, r10k_pkg::dispatch_pkt_t exp,
                                  r10k_pkg::dispatch_pkt_t act);
        if (exp !== act) begin
            err_dispatch++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_commit(string name, r10k_pkg::commit_pkt_t exp,
                                r10k_pkg::commit_pkt_t act);
        if (exp !== act) begin
            err_commit++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            err_ctrl++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(string name, r10k_pkg::addr_t exp, r10k_pkg::addr_t act);
        if (exp !== act) begin
            err_ctrl++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference decode and stimulus
    //////////////////////////////////////////////////
    function automatic r10k_pkg::decode_pkt_t model_decode(r10k_pkg::addr_t pc,
                                                           logic [31:0] inst);
        r10k_pkg::decode_pkt_t d;
        d          = '0;
        d.pc       = pc;
        d.rs1      = inst[19:15];
        d.rs2      = inst[24:20];
        d.rd       = inst[11:7];
        d.opcode   = r10k_pkg::ILLEGAL;                  // No operands unless listed below
        case (inst[6:0])
            r10k_pkg::OP: begin
                d.opcode   = r10k_pkg::OP;
                d.uses_rs1 = 1'b1;
            end
            r10k_pkg::OP_IMM: begin
                d.opcode   = r10k_pkg::OP_IMM;
                d.uses_rs1 = 1'b1;
            end
            r10k_pkg::LUI:    d.opcode = r10k_pkg::LUI;
            r10k_pkg::STORE: begin
                d.opcode   = r10k_pkg::STORE;
                d.uses_rs1 = 1'b1;
            end
            default: ;
        endcase
        d.uses_rs2 = (d.opcode == r10k_pkg::OP) || (d.opcode == r10k_pkg::STORE);
        d.has_dest = (d.opcode == r10k_pkg::OP || d.opcode == r10k_pkg::OP_IMM ||
                      d.opcode == r10k_pkg::LUI) && (inst[11:7] != 5'd0);
        return d;
    endfunction

    function automatic logic [31:0] gen_word();
        logic [31:0] w;
        logic [3:0]  pick;
        w    = $random(seed);
        pick = 4'($random(seed));
        if (w[31:29] == 3'd0)
            w[11:7] = 5'd0;                              // Extra x0 destinations
        if (pick < 4'd4)       w[6:0] = r10k_pkg::OP;
        else if (pick < 4'd8)  w[6:0] = r10k_pkg::OP_IMM;
        else if (pick < 4'd11) w[6:0] = r10k_pkg::LUI;
        else if (pick < 4'd15) w[6:0] = r10k_pkg::STORE;
        else                   w[6:0] = 7'b1111111;      // Illegal opcode now and then
        return w;
    endfunction

    // Four-phase responder with random ack delay
    task automatic answer_imem();
        logic [31:0] w;
        if (imem_ack) begin
            if (!imem_req)
                imem_ack = 1'b0;                         // Phase four
        end else if (imem_req && words.size() < NUM_TESTS) begin
            check_addr("imem_addr", r10k_pkg::addr_t'(words.size() * 4), imem_addr);
            if (delay_cnt == 0) begin
                w = gen_word();
                words.push_back(w);
                imem_data = w;
                imem_ack  = 1'b1;
                delay_cnt = $random(seed) & 7;
            end else
                delay_cnt--;
        end
    endtask

    task automatic drive_completion();
        int   k;
        logic withhold;
        withhold    = (cycle % 256) >= 128 && (cycle % 256) < 230;  // ROB fills here
        complete_in = '0;
        if (!withhold && pend_idx.size() > 0 && ($random(seed) & 3) != 0) begin
            k = int'($unsigned($random(seed)) % pend_idx.size());   // Out of order
            complete_in.valid   = 1'b1;
            complete_in.rob_idx = pend_idx[k];
            pend_idx.delete(k);
        end
    endtask

    //////////////////////////////////////////////////
    // Rename and commit model
    //////////////////////////////////////////////////
    task automatic take_dispatch();
        r10k_pkg::decode_pkt_t   d;
        r10k_pkg::dispatch_pkt_t exp;
        r10k_pkg::commit_pkt_t   c;
        if (disp_cnt >= words.size()) begin
            err_other++;
            $display("Dispatch of PC %h came before its word was fetched", dispatch_out.pc);
            return;
        end
        d            = model_decode(r10k_pkg::addr_t'(disp_cnt * 4), words[disp_cnt]);
        exp          = '0;
        exp.valid    = 1'b1;
        exp.pc       = d.pc;
        exp.opcode   = d.opcode;
        exp.src1_tag = d.uses_rs1 ? model_map[d.rs1] : '0;
        exp.src2_tag = d.uses_rs2 ? model_map[d.rs2] : '0;
        exp.has_dest = d.has_dest;
        exp.rob_idx  = r10k_pkg::rob_idx_t'(disp_cnt);   // In-order allocation from 0
        c            = '0;
        c.valid      = 1'b1;
        c.pc         = d.pc;
        c.has_dest   = d.has_dest;
        c.arch_dest  = d.rd;
        if (d.has_dest) begin
            if (model_fl.size() == 0) begin
                err_other++;
                $display("Dispatch at PC %h took a tag while no tag was free", d.pc);
                return;
            end
            exp.dest_tag     = model_fl.pop_front();
            c.new_tag        = exp.dest_tag;
            c.old_tag        = model_map[d.rd];
            model_map[d.rd]  = exp.dest_tag;
        end
        check_dispatch($sformatf("dispatch pc %h", d.pc), exp, dispatch_out);
        exp_commits.push_back(c);
        pend_idx.push_back(exp.rob_idx);
        disp_cnt++;
    endtask

    task automatic take_commit();
        r10k_pkg::commit_pkt_t c;
        if (exp_commits.size() == 0) begin
            err_other++;
            $display("Commit of PC %h arrived with nothing outstanding", commit_out.pc);
            return;
        end
        c = exp_commits.pop_front();                     // Strict program order
        check_commit($sformatf("commit pc %h", c.pc), c, commit_out);
        if (c.has_dest)
            model_fl.push_back(c.old_tag);
        commit_cnt++;
    endtask

    // Sample stable outputs, then drive inputs for the next edge
    always @(negedge clock) begin
        if (rst_n) begin
            cycle++;
            if (dispatch_out.valid)
                take_dispatch();
            if (commit_out.valid)
                take_commit();
            if (disp_cnt - commit_cnt > r10k_pkg::ROB_SZ) begin
                err_other++;
                $display("More than ROB_SZ instructions outstanding at cycle %0d", cycle);
            end
            if (disp_cnt - commit_cnt == r10k_pkg::ROB_SZ)
                stall_seen = 1'b1;
            drive_completion();
            answer_imem();
        end
    end

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////
    initial begin
        int total;
        clock       = 1'b0;
        rst_n       = 1'b0;
        imem_ack    = 1'b0;
        imem_data   = '0;
        complete_in = '0;
        for (int i = 0; i < r10k_pkg::ARCH_REGS; i++)
            model_map[i] = r10k_pkg::phys_reg_t'(i);     // Identity map after reset
        for (int i = r10k_pkg::ARCH_REGS; i < r10k_pkg::PHYS_REGS; i++)
            model_fl.push_back(r10k_pkg::phys_reg_t'(i));
        repeat (5) @(negedge clock);
        check_bit("reset imem_req", 1'b0, imem_req);
        check_bit("reset dispatch_out.valid", 1'b0, dispatch_out.valid);
        check_bit("reset commit_out.valid", 1'b0, commit_out.valid);
        check_addr("reset imem_addr", '0, imem_addr);
        rst_n <= 1'b1;
        wait (commit_cnt == NUM_TESTS);
        repeat (20) @(negedge clock);                    // Catch stray packets
        check_bit("final imem_req", 1'b1, imem_req);     // Parked on the unanswered request
        if (words.size() != NUM_TESTS || disp_cnt != NUM_TESTS || exp_commits.size() != 0) begin
            err_other++;
            $display("Lost instructions: %0d fetched, %0d dispatched, %0d committed",
                     words.size(), disp_cnt, commit_cnt);
        end
        if (int'(i_dut.i_dispatch.i_free_list.count) != model_fl.size()) begin
            err_other++;
            $display("Free list holds %0d tags where %0d should have come back",
                     i_dut.i_dispatch.i_free_list.count, model_fl.size());
        end
        if (!stall_seen) begin
            err_other++;
            $display("The ROB never filled while completions were held back");
        end
        total = err_dispatch + err_commit + err_ctrl + err_other;
        $display("Errors: dispatch %0d, commit %0d, control %0d, other %0d",
                 err_dispatch, err_commit, err_ctrl, err_other);
        if (total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired with no progress, %0d of %0d instructions committed",
                 commit_cnt, NUM_TESTS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu.sv
// Front end and rename core only; execution happens off chip and reports back by ROB index
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire                         clock,        // System clock
    input  wire                         rst_n,        // Synchronous, active low

    // Instruction memory, four-phase
    output logic                        imem_req,
    output r10k_pkg::addr_t             imem_addr,
    input  wire                         imem_ack,
    input  wire  [r10k_pkg::XLEN-1:0]   imem_data,

    // Execution side
    output r10k_pkg::dispatch_pkt_t     dispatch_out,
    input  r10k_pkg::complete_pkt_t     complete_in,
    output r10k_pkg::commit_pkt_t       commit_out
);

    //////////////////////////////////////////////////
    // Fetch to buffer
    //////////////////////////////////////////////////
    logic                  fb_valid;
    logic                  fb_ready;
    r10k_pkg::fetch_pkt_t  fb_pkt;

    // Buffer to dispatch
    logic                  bd_valid;
    logic                  bd_ready;
    r10k_pkg::fetch_pkt_t  bd_pkt;

    fetch i_fetch (
        .clock      (clock),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .push_valid (fb_valid),
        .push_pkt   (fb_pkt),
        .push_ready (fb_ready)
    );

    inst_buffer i_inst_buffer (
        .clock      (clock),
        .rst_n      (rst_n),
        .push_valid (fb_valid),
        .push_pkt   (fb_pkt),
        .push_ready (fb_ready),
        .pop_valid  (bd_valid),
        .pop_pkt    (bd_pkt),
        .pop_ready  (bd_ready)
    );

    dispatch i_dispatch (
        .clock        (clock),
        .rst_n        (rst_n),
        .pop_valid    (bd_valid),
        .pop_pkt      (bd_pkt),
        .pop_ready    (bd_ready),
        .dispatch_out (dispatch_out),
        .complete_in  (complete_in),
        .commit_out   (commit_out)
    );

endmodule

`default_nettype wire

//--- dispatch.sv
// Single-issue rename; no checkpoint of the map table, so nothing here can be undone
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  wire                      clock,
    input  wire                      rst_n,
    input  wire                      pop_valid,
    input  r10k_pkg::fetch_pkt_t     pop_pkt,
    output logic                     pop_ready,    // Low on stall
    output r10k_pkg::dispatch_pkt_t  dispatch_out,
    input  r10k_pkg::complete_pkt_t  complete_in,
    output r10k_pkg::commit_pkt_t    commit_out
);

    r10k_pkg::phys_reg_t   map_table [r10k_pkg::ARCH_REGS];
    r10k_pkg::decode_pkt_t dec;
    r10k_pkg::phys_reg_t   fl_head;
    r10k_pkg::phys_reg_t   free_tag;
    r10k_pkg::phys_reg_t   src1_tag;
    r10k_pkg::phys_reg_t   src2_tag;
    r10k_pkg::phys_reg_t   dest_tag;
    r10k_pkg::rob_idx_t    rob_tail;
    r10k_pkg::rob_entry_t  rob_entry;
    logic                  fl_empty;
    logic                  free_push;
    logic                  rob_full;
    logic                  fire;

    decoder i_decoder (.fetch_pkt(pop_pkt), .decode_pkt(dec));

    //////////////////////////////////////////////////
    // Rename
    //////////////////////////////////////////////////
    assign src1_tag  = dec.uses_rs1 ? map_table[dec.rs1] : '0;  // x0 stays at tag 0
    assign src2_tag  = dec.uses_rs2 ? map_table[dec.rs2] : '0;
    assign dest_tag  = dec.has_dest ? fl_head : '0;
    assign pop_ready = !(rob_full || (dec.has_dest && fl_empty));
    assign fire      = pop_valid && pop_ready;

    always_comb begin
        rob_entry.pc        = dec.pc;
        rob_entry.has_dest  = dec.has_dest;
        rob_entry.arch_dest = dec.rd;
        rob_entry.new_tag   = dest_tag;
        rob_entry.old_tag   = dec.has_dest ? map_table[dec.rd] : '0;  // Freed at commit
        rob_entry.done      = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < r10k_pkg::ARCH_REGS; i++)
                map_table[i] <= r10k_pkg::phys_reg_t'(i);   // Identity map
            dispatch_out.valid <= 1'b0;
        end else begin
            if (fire && dec.has_dest)
                map_table[dec.rd] <= fl_head;
            dispatch_out.valid <= fire;
            if (fire) begin
                dispatch_out.pc       <= dec.pc;
                dispatch_out.opcode   <= dec.opcode;
                dispatch_out.src1_tag <= src1_tag;
                dispatch_out.src2_tag <= src2_tag;
                dispatch_out.dest_tag <= dest_tag;
                dispatch_out.has_dest <= dec.has_dest;
                dispatch_out.rob_idx  <= rob_tail;
            end
        end
    end

    free_list i_free_list (
        .clock(clock), .rst_n(rst_n),
        .pop(fire && dec.has_dest), .head_tag(fl_head), .empty(fl_empty),
        .push(free_push), .push_tag(free_tag)
    );

    rob i_rob (
        .clock(clock), .rst_n(rst_n),
        .alloc(fire), .alloc_entry(rob_entry), .tail_idx(rob_tail), .full(rob_full),
        .complete_in(complete_in),
        .free_push(free_push), .free_tag(free_tag),
        .commit_out(commit_out)
    );

endmodule

`default_nettype wire

//--- rob.sv
// In-order ROB without squash; completions must name a live entry and arrive at most once
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     alloc,
    input  r10k_pkg::rob_entry_t    alloc_entry,
    output r10k_pkg::rob_idx_t      tail_idx,    // Index the next alloc takes
    output logic                    full,
    input  r10k_pkg::complete_pkt_t complete_in,
    output logic                    free_push,   // Old tag back to free list
    output r10k_pkg::phys_reg_t     free_tag,
    output r10k_pkg::commit_pkt_t   commit_out
);

    r10k_pkg::rob_entry_t           entries [r10k_pkg::ROB_SZ];
    r10k_pkg::rob_idx_t             head;
    r10k_pkg::rob_idx_t             tail;
    logic [r10k_pkg::ROB_CNT_W-1:0] count;
    logic                           retire;

    assign tail_idx  = tail;
    assign full      = (count == r10k_pkg::ROB_CNT_W'(r10k_pkg::ROB_SZ));
    assign retire    = (count != '0) && entries[head].done;
    assign free_push = retire && entries[head].has_dest;
    assign free_tag  = entries[head].old_tag;

    //////////////////////////////////////////////////
    // Entry storage
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (alloc)
            entries[tail] <= alloc_entry;            // Arrives with done clear
        if (complete_in.valid)
            entries[complete_in.rob_idx].done <= 1'b1;
    end

    //////////////////////////////////////////////////
    // Pointers and commit
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head             <= '0;
            tail             <= '0;
            count            <= '0;
            commit_out.valid <= 1'b0;
        end else begin
            if (alloc)
                tail <= tail + 1'b1;
            if (retire)
                head <= head + 1'b1;
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit_out.valid <= retire;              // One cycle per retirement
            if (retire) begin
                commit_out.pc        <= entries[head].pc;
                commit_out.has_dest  <= entries[head].has_dest;
                commit_out.arch_dest <= entries[head].arch_dest;
                commit_out.new_tag   <= entries[head].new_tag;
                commit_out.old_tag   <= entries[head].old_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- free_list.sv
// Holds PHYS_REGS minus ARCH_REGS tags; caller must not pop when empty nor push past capacity
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire                  pop,       // Dispatch took head_tag
    output r10k_pkg::phys_reg_t  head_tag,
    output logic                 empty,
    input  wire                  push,      // Retired old tag coming back
    input  r10k_pkg::phys_reg_t  push_tag
);

    r10k_pkg::phys_reg_t            mem [r10k_pkg::FL_DEPTH];
    logic [r10k_pkg::FL_IDX_W-1:0]  head;
    logic [r10k_pkg::FL_IDX_W-1:0]  tail;
    logic [r10k_pkg::FL_CNT_W-1:0]  count;

    assign head_tag = mem[head];
    assign empty    = (count == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // Tags above the identity map, ascending
            for (int i = 0; i < r10k_pkg::FL_DEPTH; i++)
                mem[i] <= r10k_pkg::phys_reg_t'(r10k_pkg::ARCH_REGS + i);
            head  <= '0;
            tail  <= '0;                        // Full ring so tail meets head
            count <= r10k_pkg::FL_CNT_W'(r10k_pkg::FL_DEPTH);
        end else begin
            if (push) begin
                mem[tail] <= push_tag;
                tail      <= tail + 1'b1;
            end
            if (pop)
                head <= head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Same-cycle push and pop
            endcase
        end
    end

endmodule

`default_nettype wire

//--- decoder.sv
// RV32 major opcode decode only; funct fields and immediates are left to the execution side
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  r10k_pkg::fetch_pkt_t  fetch_pkt,
    output r10k_pkg::decode_pkt_t decode_pkt
);

    logic rd_nonzero;

    assign rd_nonzero = (fetch_pkt.inst[11:7] != 5'd0);

    always_comb begin
        decode_pkt.pc       = fetch_pkt.pc;
        decode_pkt.rs1      = fetch_pkt.inst[19:15];
        decode_pkt.rs2      = fetch_pkt.inst[24:20];
        decode_pkt.rd       = fetch_pkt.inst[11:7];
        decode_pkt.opcode   = r10k_pkg::ILLEGAL;    // No operands by default
        decode_pkt.uses_rs1 = 1'b0;
        decode_pkt.uses_rs2 = 1'b0;
        decode_pkt.has_dest = 1'b0;
        case (fetch_pkt.inst[6:0])
            r10k_pkg::OP: begin                     // Register-register ALU
                decode_pkt.opcode   = r10k_pkg::OP;
                decode_pkt.uses_rs1 = 1'b1;
                decode_pkt.uses_rs2 = 1'b1;
                decode_pkt.has_dest = rd_nonzero;
            end
            r10k_pkg::OP_IMM: begin
                decode_pkt.opcode   = r10k_pkg::OP_IMM;
                decode_pkt.uses_rs1 = 1'b1;
                decode_pkt.has_dest = rd_nonzero;
            end
            r10k_pkg::LUI: begin                    // Immediate only
                decode_pkt.opcode   = r10k_pkg::LUI;
                decode_pkt.has_dest = rd_nonzero;
            end
            r10k_pkg::STORE: begin                  // rd field holds imm bits
                decode_pkt.opcode   = r10k_pkg::STORE;
                decode_pkt.uses_rs1 = 1'b1;
                decode_pkt.uses_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- inst_buffer.sv
// Fetch packet FIFO; IB_DEPTH must be a power of two, no flush since there are no branches
`timescale 1ns/1ps
`default_nettype none

module inst_buffer (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire                    push_valid,
    input  r10k_pkg::fetch_pkt_t   push_pkt,
    output logic                   push_ready,  // Not full
    output logic                   pop_valid,   // Not empty
    output r10k_pkg::fetch_pkt_t   pop_pkt,
    input  wire                    pop_ready
);

    r10k_pkg::fetch_pkt_t                mem [r10k_pkg::IB_DEPTH];
    logic [r10k_pkg::IB_IDX_W-1:0]       head;
    logic [r10k_pkg::IB_IDX_W-1:0]       tail;
    logic [r10k_pkg::IB_CNT_W-1:0]       count;
    logic                                do_push;
    logic                                do_pop;

    assign push_ready = (count != r10k_pkg::IB_CNT_W'(r10k_pkg::IB_DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_pkt    = mem[head];              // Head is read straight out
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    // Storage
    always_ff @(posedge clock) begin
        if (do_push)
            mem[tail] <= push_pkt;
    end

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push)
                tail <= tail + 1'b1;            // Wraps at IB_DEPTH
            if (do_pop)
                head <= head + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fetch.sv
// Straight-line fetch from PC 0 with no branches; one outstanding imem request at a time
`timescale 1ns/1ps
`default_nettype none

module fetch (
    input  wire                          clock,
    input  wire                          rst_n,
    output logic                         imem_req,   // Four-phase request
    output r10k_pkg::addr_t              imem_addr,  // Steady while req is high
    input  wire                          imem_ack,
    input  wire  [r10k_pkg::XLEN-1:0]    imem_data,
    output logic                         push_valid, // Captured word waiting for buffer
    output r10k_pkg::fetch_pkt_t         push_pkt,
    input  wire                          push_ready
);

    r10k_pkg::fetch_state_e state;
    r10k_pkg::addr_t        pc;
    r10k_pkg::fetch_pkt_t   held_pkt;                // Captured word with its PC
    logic                   held_valid;

    assign imem_req   = (state == r10k_pkg::REQ);
    assign imem_addr  = pc;
    assign push_valid = held_valid;
    assign push_pkt   = held_pkt;

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= r10k_pkg::IDLE;
            pc         <= '0;
            held_valid <= 1'b0;
        end else begin
            if (held_valid && push_ready)
                held_valid <= 1'b0;                  // Buffer took the word
            case (state)
                r10k_pkg::IDLE: begin
                    if (!held_valid)                 // Never two words in hand
                        state <= r10k_pkg::REQ;
                end
                r10k_pkg::REQ: begin
                    if (imem_ack) begin
                        held_pkt.pc   <= pc;         // Capture with its address
                        held_pkt.inst <= imem_data;
                        held_valid    <= 1'b1;
                        pc            <= pc + 32'd4;
                        state         <= r10k_pkg::RELEASE;
                    end
                end
                r10k_pkg::RELEASE: begin
                    if (!imem_ack)                   // Memory finished its half
                        state <= r10k_pkg::IDLE;
                end
                default: state <= r10k_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- r10k_pkg.sv
// Shared widths and types; the depths must stay powers of two because the pointers wrap freely
`default_nettype none

package r10k_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int XLEN      = 32;                    // Data and address width
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int ROB_SZ    = 8;
    localparam int IB_DEPTH  = 4;

    localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS; // Tags never held by the map table
    localparam int FL_IDX_W  = $clog2(FL_DEPTH);
    localparam int FL_CNT_W  = $clog2(FL_DEPTH + 1);
    localparam int IB_IDX_W  = $clog2(IB_DEPTH);
    localparam int IB_CNT_W  = $clog2(IB_DEPTH + 1);
    localparam int ROB_CNT_W = $clog2(ROB_SZ + 1);

    typedef logic [XLEN-1:0]              addr_t;
    typedef logic [4:0]                   arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_SZ)-1:0]    rob_idx_t;

    // RV32 major opcodes kept by this core
    typedef enum logic [6:0] {
        OP      = 7'b0110011,
        OP_IMM  = 7'b0010011,
        LUI     = 7'b0110111,
        STORE   = 7'b0100011,
        ILLEGAL = 7'b0000000  // Anything else
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,                 // Free to start a request
        REQ,                  // req high, waiting for ack
        RELEASE               // req low, waiting for ack to fall
    } fetch_state_e;

    //////////////////////////////////////////////////
    // Packets
    //////////////////////////////////////////////////
    typedef struct packed {
        addr_t             pc;
        logic [XLEN-1:0]   inst;
    } fetch_pkt_t;

    typedef struct packed {
        addr_t     pc;
        opcode_e   opcode;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      has_dest;  // Never set for rd of x0
    } decode_pkt_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        opcode_e   opcode;
        phys_reg_t src1_tag;  // 0 when unused
        phys_reg_t src2_tag;
        phys_reg_t dest_tag;
        logic      has_dest;
        rob_idx_t  rob_idx;
    } dispatch_pkt_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } complete_pkt_t;

    typedef struct packed {
        addr_t     pc;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_reg_t new_tag;
        phys_reg_t old_tag;   // Freed at retirement
        logic      done;
    } rob_entry_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_reg_t new_tag;
        phys_reg_t old_tag;
    } commit_pkt_t;

endpackage

`default_nettype wire
